// File: logic/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Instruction fields
    localparam int opcode_w = 6;
    localparam int funct_w  = 6;

    localparam logic [opcode_w-1:0] OP_RTYPE = 6'h00;
    localparam logic [opcode_w-1:0] OP_ADDI  = 6'h08;
    localparam logic [opcode_w-1:0] OP_ADDIU = 6'h09;

    localparam logic [funct_w-1:0] FN_ADD = 6'h20;
    localparam logic [funct_w-1:0] FN_SUB = 6'h22;
    localparam logic [funct_w-1:0] FN_AND = 6'h24;

    // Fixed memory latencies
    localparam int MEM_WAIT_CYCLES = 3;
    localparam int EXC_WAIT_CYCLES = 8;
    localparam int wait_cnt_w      = 4;

    localparam logic [2:0] ALU_OP_ADD = 3'b001;
    localparam logic [2:0] ALU_OP_AND = 3'b010;
    localparam logic [2:0] ALU_OP_SUB = 3'b011;

    localparam logic [1:0] ALU_A_PC  = 2'b00;
    localparam logic [1:0] ALU_A_REG = 2'b01;

    localparam logic [2:0] ALU_B_REG  = 3'b000;
    localparam logic [2:0] ALU_B_FOUR = 3'b001;
    localparam logic [2:0] ALU_B_IMM  = 3'b010;

    localparam logic [2:0] IORD_PC     = 3'b000;
    localparam logic [2:0] IORD_VECTOR = 3'b010;

    localparam logic [1:0] DST_RT = 2'b00;
    localparam logic [1:0] DST_RD = 2'b01;
    localparam logic [1:0] DST_SP = 2'b10;

    localparam logic [3:0] TOREG_ALU     = 4'b0000;
    localparam logic [3:0] TOREG_SP_INIT = 4'b0100;

    localparam logic [2:0] PC_SRC_ALU    = 3'b000;
    localparam logic [2:0] PC_SRC_VECTOR = 3'b011;

    // Cause written with the EPC
    localparam logic [1:0] EXC_OPCODE   = 2'b00;
    localparam logic [1:0] EXC_OVERFLOW = 2'b01;

    typedef enum logic [2:0] {
        CLS_ADD, CLS_SUB, CLS_AND, CLS_ADDI, CLS_ADDIU, CLS_ILLEGAL
    } instr_class_e;

    typedef enum logic [3:0] {
        S_STACK_INIT, S_FETCH_WAIT, S_FETCH, S_DECODE, S_DISPATCH,
        S_EXEC_ADD, S_EXEC_SUB, S_EXEC_AND, S_EXEC_ADDI, S_EXEC_ADDIU,
        S_CHECK_R, S_CHECK_I, S_WRITE_R, S_WRITE_I,
        S_EXC_WAIT, S_EXC_ENTER
    } ctrl_state_e;

    typedef struct packed {
        logic       pc_write;
        logic       ir_write;
        logic       a_write;
        logic       b_write;
        logic       alu_reg_write;
        logic       epc_write;
        logic       reg_write;
        logic [1:0] reg_dst;
        logic [1:0] except_code;
        logic [1:0] alu_src_a;
        logic [2:0] iord;
        logic [2:0] alu_src_b;
        logic [2:0] alu_op;
        logic [2:0] pc_src;
        logic [3:0] mem_to_reg;
    } ctrl_word_t;

endpackage

// File: logic/opcode_decoder.sv
`timescale 1ns/100ps

module opcode_decoder (
    input  logic [cpu_ctrl_pkg::opcode_w-1:0] opcode,
    input  logic [cpu_ctrl_pkg::funct_w-1:0]  funct,
    output cpu_ctrl_pkg::instr_class_e        cls
);
    import cpu_ctrl_pkg::*;

    instr_class_e rtype_cls;

    // funct only means something under the R-type opcode
    always_comb begin
        case (funct)
            FN_ADD:  rtype_cls = CLS_ADD;
            FN_SUB:  rtype_cls = CLS_SUB;
            FN_AND:  rtype_cls = CLS_AND;
            default: rtype_cls = CLS_ILLEGAL;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_RTYPE: begin
                cls = rtype_cls;
            end
            OP_ADDI: begin
                cls = CLS_ADDI;
            end
            OP_ADDIU: begin
                cls = CLS_ADDIU;
            end
            default: begin
                cls = CLS_ILLEGAL;
            end
        endcase
    end

endmodule

// File: logic/ctrl_fsm.sv
`timescale 1ns/100ps

module ctrl_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  cpu_ctrl_pkg::instr_class_e  cls,
    input  logic                        ov,
    output cpu_ctrl_pkg::ctrl_state_e   state,
    output logic [1:0]                  exc_code
);
    import cpu_ctrl_pkg::*;

    ctrl_state_e           next_state;
    logic [1:0]            next_exc;
    logic [wait_cnt_w-1:0] wait_cnt;
    logic                  wait_done;
    logic                  in_wait;
    logic                  enter_mem_wait;
    logic                  enter_exc_wait;

    assign wait_done      = (wait_cnt == '0);
    assign in_wait        = (state == S_FETCH_WAIT) || (state == S_EXC_WAIT);
    assign enter_mem_wait = (next_state == S_FETCH_WAIT) && (state != S_FETCH_WAIT);
    assign enter_exc_wait = (next_state == S_EXC_WAIT) && (state != S_EXC_WAIT);

    always_comb begin
        next_state = state;
        next_exc   = exc_code;
        case (state)
            S_STACK_INIT: begin
                next_state = S_FETCH_WAIT;
            end
            S_FETCH_WAIT: begin
                if (wait_done)
                    next_state = S_FETCH;
            end
            S_FETCH: begin
                next_state = S_DECODE;
            end
            S_DECODE: begin
                next_state = S_DISPATCH;
            end
            S_DISPATCH: begin
                case (cls)
                    CLS_ADD:   next_state = S_EXEC_ADD;
                    CLS_SUB:   next_state = S_EXEC_SUB;
                    CLS_AND:   next_state = S_EXEC_AND;
                    CLS_ADDI:  next_state = S_EXEC_ADDI;
                    CLS_ADDIU: next_state = S_EXEC_ADDIU;
                    default: begin
                        next_state = S_EXC_WAIT;
                        next_exc   = EXC_OPCODE;
                    end
                endcase
            end
            S_EXEC_ADD, S_EXEC_SUB, S_EXEC_AND: begin
                next_state = S_CHECK_R;
            end
            S_EXEC_ADDI: begin
                next_state = S_CHECK_I;
            end
            // addiu cannot trap, skip the check
            S_EXEC_ADDIU: begin
                next_state = S_WRITE_I;
            end
            S_CHECK_R, S_CHECK_I: begin
                if (ov) begin
                    next_state = S_EXC_WAIT;
                    next_exc   = EXC_OVERFLOW;
                end else if (state == S_CHECK_R) begin
                    next_state = S_WRITE_R;
                end else begin
                    next_state = S_WRITE_I;
                end
            end
            S_WRITE_R, S_WRITE_I: begin
                next_state = S_FETCH_WAIT;
            end
            S_EXC_WAIT: begin
                if (wait_done)
                    next_state = S_EXC_ENTER;
            end
            S_EXC_ENTER: begin
                next_state = S_FETCH_WAIT;
            end
            default: begin
                next_state = S_STACK_INIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_STACK_INIT;
            exc_code <= EXC_OPCODE;
            wait_cnt <= '0;
        end else begin
            state    <= next_state;
            exc_code <= next_exc;
            // Counts down to zero in the last wait cycle
            if (enter_mem_wait)
                wait_cnt <= wait_cnt_w'(MEM_WAIT_CYCLES - 1);
            else if (enter_exc_wait)
                wait_cnt <= wait_cnt_w'(EXC_WAIT_CYCLES - 1);
            else if (in_wait && !wait_done)
                wait_cnt <= wait_cnt - 1'b1;
        end
    end

endmodule

// File: logic/ctrl_word_gen.sv
`timescale 1ns/100ps

module ctrl_word_gen (
    input  cpu_ctrl_pkg::ctrl_state_e state,
    input  logic [1:0]                exc_code,
    output cpu_ctrl_pkg::ctrl_word_t  ctrl
);
    import cpu_ctrl_pkg::*;

    always_comb begin
        ctrl = '0;
        case (state)
            // Load the stack pointer into the register file
            S_STACK_INIT: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = DST_SP;
                ctrl.mem_to_reg = TOREG_SP_INIT;
            end
            // PC + 4 computed while memory is read
            S_FETCH_WAIT, S_FETCH: begin
                ctrl.iord      = IORD_PC;
                ctrl.alu_src_a = ALU_A_PC;
                ctrl.alu_src_b = ALU_B_FOUR;
                ctrl.alu_op    = ALU_OP_ADD;
                ctrl.pc_src    = PC_SRC_ALU;
                ctrl.pc_write  = (state == S_FETCH);
                ctrl.ir_write  = (state == S_FETCH);
            end
            S_DECODE: begin
                ctrl.a_write = 1'b1;
                ctrl.b_write = 1'b1;
            end
            S_EXEC_ADD, S_EXEC_SUB, S_EXEC_AND: begin
                ctrl.alu_src_a     = ALU_A_REG;
                ctrl.alu_src_b     = ALU_B_REG;
                ctrl.alu_reg_write = 1'b1;
                case (state)
                    S_EXEC_SUB: ctrl.alu_op = ALU_OP_SUB;
                    S_EXEC_AND: ctrl.alu_op = ALU_OP_AND;
                    default:    ctrl.alu_op = ALU_OP_ADD;
                endcase
            end
            S_EXEC_ADDI, S_EXEC_ADDIU: begin
                ctrl.alu_src_a     = ALU_A_REG;
                ctrl.alu_src_b     = ALU_B_IMM;
                ctrl.alu_op        = ALU_OP_ADD;
                ctrl.alu_reg_write = 1'b1;
            end
            // Idle while the datapath settles
            S_DISPATCH, S_CHECK_R, S_CHECK_I: begin
                ctrl = '0;
            end
            S_WRITE_R: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = DST_RD;
                ctrl.mem_to_reg = TOREG_ALU;
            end
            S_WRITE_I: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = DST_RT;
                ctrl.mem_to_reg = TOREG_ALU;
            end
            // Cause selects which vector is read
            S_EXC_WAIT: begin
                ctrl.except_code = exc_code;
                ctrl.iord        = IORD_VECTOR;
            end
            S_EXC_ENTER: begin
                ctrl.epc_write = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_src    = PC_SRC_VECTOR;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: logic/control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cpu_ctrl_pkg::opcode_w-1:0] opcode,
    input  logic [cpu_ctrl_pkg::funct_w-1:0]  funct,
    input  logic                              ov,
    output cpu_ctrl_pkg::ctrl_word_t          ctrl
);
    import cpu_ctrl_pkg::*;

    instr_class_e cls;
    ctrl_state_e  state;
    logic [1:0]   exc_code;

    opcode_decoder decoder_i (
        .opcode (opcode),
        .funct  (funct),
        .cls    (cls)
    );

    ctrl_fsm fsm_i (
        .clk      (clk),
        .reset    (reset),
        .cls      (cls),
        .ov       (ov),
        .state    (state),
        .exc_code (exc_code)
    );

    ctrl_word_gen word_gen_i (
        .state    (state),
        .exc_code (exc_code),
        .ctrl     (ctrl)
    );

endmodule

// File: dv/control_unit_properties.sv
`timescale 1ns/100ps

module control_unit_properties (
    input logic                      clk,
    input logic                      reset,
    input cpu_ctrl_pkg::ctrl_state_e state,
    input logic [1:0]                exc_code
);
    import cpu_ctrl_pkg::*;

    ctrl_word_t ctrl;

    // Word as the datapath sees it
    ctrl_word_gen word_i (
        .state    (state),
        .exc_code (exc_code),
        .ctrl     (ctrl)
    );

    ir_single: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_write |=> !ctrl.ir_write)
        else $error("ir_write high on two consecutive cycles");

    epc_with_pc: assert property (@(posedge clk) disable iff (reset)
        ctrl.epc_write |-> ctrl.pc_write)
        else $error("epc_write without pc_write");

    // Register file is never written while the IR loads
    no_write_on_fetch: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.reg_write && ctrl.ir_write))
        else $error("reg_write together with ir_write");

endmodule

bind ctrl_fsm control_unit_properties props_i (
    .clk      (clk),
    .reset    (reset),
    .state    (state),
    .exc_code (exc_code)
);

// File: dv/control_unit_tb.sv
`timescale 1ns/100ps

module control_unit_tb;
    import cpu_ctrl_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int INSTR_PER_TEST = 40;
    localparam int NUM_TESTS      = 5;
    localparam int MAX_CYCLES     = RESET_CYCLES + NUM_TESTS * INSTR_PER_TEST * 17 + 100;

    localparam int K_RTYPE    = 0;
    localparam int K_ITYPE    = 1;
    localparam int K_ILLEGAL  = 2;
    localparam int K_OVERFLOW = 3;

    logic                clk;
    logic                reset;
    logic [opcode_w-1:0] opcode;
    logic [funct_w-1:0]  funct;
    logic                ov;
    ctrl_word_t          ctrl;

    int    seed;
    int    cycles = 0;
    int    errors;
    int    checks;
    int    err0;
    int    chk0;
    int    entries;
    string cur_test;
    logic  ir_seen;

    // Reference model state
    ctrl_state_e m_state;
    logic [1:0]  m_exc;
    int          m_left;
    int          exp_len;
    int          len_cnt;
    int          fw_run;
    logic        model_on;
    logic        have_instr;
    ctrl_word_t  prev_ctrl;
    ctrl_word_t  fw_word;

    control_unit dut_i (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ov     (ov),
        .ctrl   (ctrl)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic instr_class_e class_of(input logic [opcode_w-1:0] op,
                                              input logic [funct_w-1:0] fn);
        instr_class_e c;
        c = CLS_ILLEGAL;
        if (op == OP_ADDI)
            c = CLS_ADDI;
        else if (op == OP_ADDIU)
            c = CLS_ADDIU;
        else if (op == OP_RTYPE && fn == FN_ADD)
            c = CLS_ADD;
        else if (op == OP_RTYPE && fn == FN_SUB)
            c = CLS_SUB;
        else if (op == OP_RTYPE && fn == FN_AND)
            c = CLS_AND;
        return c;
    endfunction

    function automatic ctrl_word_t expected_word(input ctrl_state_e s, input logic [1:0] exc);
        ctrl_word_t w;
        w = '0;
        case (s)
            S_STACK_INIT: begin
                w.reg_write  = 1'b1;
                w.reg_dst    = DST_SP;
                w.mem_to_reg = TOREG_SP_INIT;
            end
            S_FETCH_WAIT, S_FETCH: begin
                w.iord      = IORD_PC;
                w.alu_src_a = ALU_A_PC;
                w.alu_src_b = ALU_B_FOUR;
                w.alu_op    = ALU_OP_ADD;
                w.pc_write  = (s == S_FETCH);
                w.ir_write  = (s == S_FETCH);
            end
            S_DECODE: begin
                w.a_write = 1'b1;
                w.b_write = 1'b1;
            end
            S_EXEC_ADD, S_EXEC_SUB, S_EXEC_AND, S_EXEC_ADDI, S_EXEC_ADDIU: begin
                w.alu_src_a     = ALU_A_REG;
                w.alu_reg_write = 1'b1;
                w.alu_src_b     = (s == S_EXEC_ADDI || s == S_EXEC_ADDIU) ? ALU_B_IMM : ALU_B_REG;
                w.alu_op        = (s == S_EXEC_SUB) ? ALU_OP_SUB :
                                  (s == S_EXEC_AND) ? ALU_OP_AND : ALU_OP_ADD;
            end
            S_WRITE_R, S_WRITE_I: begin
                w.reg_write  = 1'b1;
                w.reg_dst    = (s == S_WRITE_R) ? DST_RD : DST_RT;
                w.mem_to_reg = TOREG_ALU;
            end
            S_EXC_WAIT: begin
                w.except_code = exc;
                w.iord        = IORD_VECTOR;
            end
            S_EXC_ENTER: begin
                w.epc_write = 1'b1;
                w.pc_write  = 1'b1;
                w.pc_src    = PC_SRC_VECTOR;
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    task automatic step_model;
        ctrl_state_e  nxt;
        instr_class_e c;
        c   = class_of(opcode, funct);
        nxt = m_state;
        case (m_state)
            S_STACK_INIT, S_WRITE_R, S_WRITE_I, S_EXC_ENTER: nxt = S_FETCH_WAIT;
            S_FETCH_WAIT: nxt = (m_left > 1) ? S_FETCH_WAIT : S_FETCH;
            S_FETCH:      nxt = S_DECODE;
            S_DECODE:     nxt = S_DISPATCH;
            S_DISPATCH: begin
                have_instr = 1'b1;
                exp_len    = (c == CLS_ADDIU) ? 8 : 9;
                case (c)
                    CLS_ADD:   nxt = S_EXEC_ADD;
                    CLS_SUB:   nxt = S_EXEC_SUB;
                    CLS_AND:   nxt = S_EXEC_AND;
                    CLS_ADDI:  nxt = S_EXEC_ADDI;
                    CLS_ADDIU: nxt = S_EXEC_ADDIU;
                    default: begin
                        nxt     = S_EXC_WAIT;
                        m_exc   = EXC_OPCODE;
                        exp_len = 15;
                    end
                endcase
            end
            S_EXEC_ADD, S_EXEC_SUB, S_EXEC_AND: nxt = S_CHECK_R;
            S_EXEC_ADDI:  nxt = S_CHECK_I;
            S_EXEC_ADDIU: nxt = S_WRITE_I;
            S_CHECK_R, S_CHECK_I: begin
                if (ov) begin
                    nxt     = S_EXC_WAIT;
                    m_exc   = EXC_OVERFLOW;
                    exp_len = 17;
                end else begin
                    nxt = (m_state == S_CHECK_R) ? S_WRITE_R : S_WRITE_I;
                end
            end
            S_EXC_WAIT: nxt = (m_left > 1) ? S_EXC_WAIT : S_EXC_ENTER;
            default:    nxt = S_STACK_INIT;
        endcase
        if (nxt == S_FETCH_WAIT && m_state != S_FETCH_WAIT)
            m_left = MEM_WAIT_CYCLES;
        else if (nxt == S_EXC_WAIT && m_state != S_EXC_WAIT)
            m_left = EXC_WAIT_CYCLES;
        else
            m_left = m_left - 1;
        m_state = nxt;
    endtask

    task automatic check_ctrl(input ctrl_word_t exp, input ctrl_word_t act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERROR %s: ctrl in %s expected %h actual %h",
                     cur_test, m_state.name(), exp, act);
        end
    endtask

    task automatic check_len(input string what, input int exp, input int act);
        checks = checks + 1;
        if (act != exp) begin
            errors = errors + 1;
            $display("ERROR %s: %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (model_on) begin
            check_ctrl(expected_word(m_state, m_exc), ctrl);
            if (ctrl == fw_word && prev_ctrl != fw_word) begin
                if (have_instr)
                    check_len("instruction length", exp_len, len_cnt);
                len_cnt = 1;
                entries = entries + 1;
            end else begin
                len_cnt = len_cnt + 1;
            end
            if (ctrl == fw_word) begin
                fw_run = fw_run + 1;
            end else if (ctrl.ir_write) begin
                check_len("fetch wait cycles", MEM_WAIT_CYCLES, fw_run);
                fw_run = 0;
            end
        end
        prev_ctrl = ctrl;
        ir_seen   = ctrl.ir_write;
        if (reset) begin
            m_state  = S_STACK_INIT;
            m_left   = 0;
            model_on = 1'b1;
        end else if (model_on) begin
            step_model();
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic draw_ov(input int kind);
        logic r;
        r = 1'($random(seed));
        if (kind == K_RTYPE)
            r = 1'b0;
        else if (kind == K_OVERFLOW)
            r = 1'b1;
        return r;
    endfunction

    task automatic draw_instr(input int kind);
        logic [opcode_w-1:0] op;
        logic [funct_w-1:0]  fn;
        int                  pick;
        pick = $unsigned($random(seed)) % 4;
        fn   = funct_w'($random(seed));
        case (kind)
            K_RTYPE: begin
                op = OP_RTYPE;
                fn = (pick == 0) ? FN_SUB : (pick == 1) ? FN_AND : FN_ADD;
            end
            K_ITYPE: begin
                op = pick[0] ? OP_ADDI : OP_ADDIU;
            end
            K_ILLEGAL: begin
                // Half of them are bad funct codes under R-type
                do begin
                    op = pick[0] ? OP_RTYPE : opcode_w'($random(seed));
                    fn = funct_w'($random(seed));
                end while (class_of(op, fn) != CLS_ILLEGAL);
            end
            default: begin
                op = (pick == 3) ? OP_ADDI : OP_RTYPE;
                fn = (pick == 1) ? FN_SUB : (pick == 2) ? FN_AND : FN_ADD;
            end
        endcase
        opcode <= op;
        funct  <= fn;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err0     = errors;
        chk0     = checks;
    endtask

    task automatic end_test;
        $display("Test %-8s done: %0d checks, %0d errors", cur_test, checks - chk0, errors - err0);
    endtask

    task automatic run_test(input int kind, input string name);
        int n;
        int last_entry;
        n          = 0;
        last_entry = entries;
        start_test(name);
        // Last instruction must reach the next fetch before the test ends
        while (n < INSTR_PER_TEST || entries == last_entry) begin
            if (ir_seen && n < INSTR_PER_TEST) begin
                draw_instr(kind);
                n          = n + 1;
                last_entry = entries;
            end
            ov <= draw_ov(kind);
            @(posedge clk);
        end
        end_test();
    endtask

    initial begin
        seed       = 32'h8a38;
        reset      = 1'b1;
        opcode     = '0;
        funct      = '0;
        ov         = 1'b0;
        errors     = 0;
        checks     = 0;
        entries    = 0;
        ir_seen    = 1'b0;
        model_on   = 1'b0;
        have_instr = 1'b0;
        m_state    = S_STACK_INIT;
        m_exc      = EXC_OPCODE;
        m_left     = 0;
        exp_len    = 0;
        len_cnt    = 0;
        fw_run     = 0;
        prev_ctrl  = '0;
        fw_word    = expected_word(S_FETCH_WAIT, EXC_OPCODE);

        start_test("reset");
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        do @(posedge clk); while (!ir_seen);
        end_test();

        run_test(K_RTYPE, "rtype");
        run_test(K_ITYPE, "itype");
        run_test(K_ILLEGAL, "illegal");
        run_test(K_OVERFLOW, "overflow");

        $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: verilog.f
logic/cpu_ctrl_pkg.sv
logic/opcode_decoder.sv
logic/ctrl_fsm.sv
logic/ctrl_word_gen.sv
logic/control_unit.sv
dv/control_unit_properties.sv
dv/control_unit_tb.sv

// File: Makefile
TOP := control_unit_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
